/* source/frogger_cfg.svh */
// road scene configuration
// screen geometry, lane layout, hud placement and timer length
`ifndef FROGGER_CFG_SVH
`define FROGGER_CFG_SVH

// visible screen
`define SCREEN_W 640
`define COORD_W 10

// frog box
`define FROG_W 17
`define FROG_H 16

//**************************************************
// traffic lanes
//**************************************************
// lane 0 fire trucks moving left
`define FIRETRUCK_Y 342
`define FIRETRUCK_W 25
`define FIRETRUCK_H 16
`define FIRETRUCK_LEFT 1'b1
`define FIRETRUCK_X0 440
`define FIRETRUCK_X1 400
`define FIRETRUCK_X2 280
`define FIRETRUCK_X3 200
`define FIRETRUCK_X4 100

// lane 1 buses moving right
`define BUS_Y 323
`define BUS_W 19
`define BUS_H 14
`define BUS_LEFT 1'b0
`define BUS_X0 440
`define BUS_X1 400
`define BUS_X2 300
`define BUS_X3 180
`define BUS_X4 60

// lane 2 motorcycles moving left
`define MOTO_Y 302
`define MOTO_W 23
`define MOTO_H 16
`define MOTO_LEFT 1'b1
`define MOTO_X0 440
`define MOTO_X1 400
`define MOTO_X2 300
`define MOTO_X3 250
`define MOTO_X4 120

// lane 3 police cars moving right
`define POLICE_Y 284
`define POLICE_W 28
`define POLICE_H 12
`define POLICE_LEFT 1'b0
`define POLICE_X0 440
`define POLICE_X1 60
`define POLICE_X2 380
`define POLICE_X3 600
`define POLICE_X4 560

// lane 4 trucks moving left
`define TRUCK_Y 263
`define TRUCK_W 25
`define TRUCK_H 14
`define TRUCK_LEFT 1'b1
`define TRUCK_X0 440
`define TRUCK_X1 380
`define TRUCK_X2 300
`define TRUCK_X3 150
`define TRUCK_X4 90

//**************************************************
// hud
//**************************************************
// time bar, width in pixels and ticks per pixel
`define BAR_X 430
`define BAR_Y 400
`define BAR_H 15
`define BAR_MAX 160
`define BAR_DIV 4

// life hearts
`define HEART_Y 400
`define HEART_X0 100
`define HEART_STEP 20
`define HEART_W 14
`define HEART_H 12

// purple dividers, rows inclusive
`define DIV0_TOP 240
`define DIV0_BOT 260
`define DIV1_TOP 360
`define DIV1_BOT 380

// water fills every row above this one
`define WATER_END 240

`endif

/* source/froggerPkg.sv */
// shared types of the road scene
// screen coordinate and palette indices
`include "frogger_cfg.svh"

package froggerPkg;

	// pixel, frog and vehicle coordinates
	typedef logic [`COORD_W-1:0] coord_t;

	//**************************************************
	// palette
	//**************************************************
	// index into the display colour table
	// gaps belong to colours the road scene never draws
	typedef enum logic [5:0]
	{
		colWhite      = 6'd0,
		colGreen      = 6'd2,
		colRed        = 6'd3,
		colLightBlue  = 6'd4,
		colYellow     = 6'd5,
		colOrange     = 6'd7,
		colBrown      = 6'd8,
		colPurple     = 6'd9,
		colDarkBlue   = 6'd10,
		colLightGreen = 6'd12,
		colDarkGrey   = 6'd13
	} colorCode_t;

endpackage

/* source/trafficLane.sv */
// one traffic lane of five vehicles
// every vehicle moves one pixel per tick and wraps at the screen edge
// flags whether the draw point or the frog anchor lies on a vehicle
`timescale 1ns/1ps
`include "frogger_cfg.svh"

module trafficLane
	import froggerPkg::*;
#(
	parameter coord_t laneY   = 0,
	parameter coord_t spriteW = 1,
	parameter coord_t spriteH = 1,
	parameter bit     moveLeft = 1'b1,
	parameter coord_t start0  = 0,
	parameter coord_t start1  = 0,
	parameter coord_t start2  = 0,
	parameter coord_t start3  = 0,
	parameter coord_t start4  = 0
)
(
	input  logic   clk_4Hz,
	input  logic   arstN,
	input  coord_t drawX,
	input  coord_t drawY,
	input  coord_t frogX,
	input  coord_t frogY,
	output logic   drawHit,
	output logic   frogHit
);

	localparam int numVeh = 5;
	localparam coord_t startPos [numVeh] = '{start0, start1, start2, start3, start4};

	coord_t vehX [numVeh];
	logic [numVeh-1:0] drawHitVec;
	logic [numVeh-1:0] frogHitVec;

	// point inside the box of a vehicle whose left edge is at bx
	function automatic logic inVehicle(input coord_t px, input coord_t py, input coord_t bx);
		return (px >= bx) && (px < bx + spriteW) && (py >= laneY) && (py < laneY + spriteH);
	endfunction

	// next position in the lane direction
	function automatic coord_t stepPos(input coord_t x);
		if (moveLeft)
			return (x == '0) ? coord_t'(`SCREEN_W) : x - 1'b1;
		else
			return (x == coord_t'(`SCREEN_W)) ? '0 : x + 1'b1;
	endfunction

	//**************************************************
	// vehicle movement
	//**************************************************
	always_ff @(posedge clk_4Hz or negedge arstN)
	begin
		if (!arstN)
		begin
			for (int i = 0; i < numVeh; i++)
				vehX[i] <= startPos[i];
		end
		else
		begin
			for (int i = 0; i < numVeh; i++)
				vehX[i] <= stepPos(vehX[i]);
		end
	end

	//**************************************************
	// hit tests
	//**************************************************
	always_comb
	begin
		for (int i = 0; i < numVeh; i++)
		begin
			drawHitVec[i] = inVehicle(drawX, drawY, vehX[i]);
			frogHitVec[i] = inVehicle(frogX, frogY, vehX[i]);
		end
	end

	assign drawHit = |drawHitVec;
	assign frogHit = |frogHitVec;

	// wrap keeps every vehicle between 0 and the right screen edge
	for (genvar g = 0; g < numVeh; g++)
	begin : genBound
		assert property (@(posedge clk_4Hz) disable iff (!arstN)
			vehX[g] <= coord_t'(`SCREEN_W))
		else
			$error("vehicle %0d left the screen range at x=%0d", g, vehX[g]);
	end

endmodule

/* source/timeBar.sv */
// time bar countdown
// width shrinks one pixel every BAR_DIV ticks and refills after zero
`timescale 1ns/1ps
`include "frogger_cfg.svh"

module timeBar
	import froggerPkg::*;
(
	input  logic   clk_4Hz,
	input  logic   arstN,
	input  coord_t drawX,
	input  coord_t drawY,
	output logic   barHit
);

	localparam int divW   = $clog2(`BAR_DIV);
	localparam int widthW = $clog2(`BAR_MAX + 1);

	logic [divW-1:0]   divCnt;
	logic [widthW-1:0] barWidth;

	// tick divider and width counter
	always_ff @(posedge clk_4Hz or negedge arstN)
	begin
		if (!arstN)
		begin
			divCnt   <= '0;
			barWidth <= widthW'(`BAR_MAX);
		end
		else if (divCnt == divW'(`BAR_DIV - 1))
		begin
			divCnt <= '0;
			// refill once the bar has run out
			barWidth <= (barWidth == '0) ? widthW'(`BAR_MAX) : barWidth - 1'b1;
		end
		else
		begin
			divCnt <= divCnt + 1'b1;
		end
	end

	// bar grows rightwards from BAR_X
	assign barHit = (drawX >= `BAR_X) && (drawX < `BAR_X + barWidth) &&
		(drawY >= `BAR_Y) && (drawY < `BAR_Y + `BAR_H);

	assert property (@(posedge clk_4Hz) disable iff (!arstN)
		barWidth <= widthW'(`BAR_MAX))
	else
		$error("time bar width %0d above maximum", barWidth);

endmodule

/* source/hudOverlay.sv */
// static hud shapes
// life hearts, the two purple dividers and the water band
`timescale 1ns/1ps
`include "frogger_cfg.svh"

module hudOverlay
	import froggerPkg::*;
(
	input  coord_t     drawX,
	input  coord_t     drawY,
	input  logic [2:0] lives,
	output logic       heartHit,
	output logic       lineHit,
	output logic       waterHit
);

	localparam int numHearts = 3;

	logic [numHearts-1:0] heartVec;

	//**************************************************
	// hearts
	//**************************************************
	// heart k shows for lives k+1 up to 3
	// larger lives values draw nothing
	for (genvar k = 0; k < numHearts; k++)
	begin : genHeart
		localparam coord_t heartX = coord_t'(`HEART_X0 + k * `HEART_STEP);

		assign heartVec[k] = (lives > k) && (lives <= 3'd3) &&
			(drawX >= heartX) && (drawX < heartX + `HEART_W) &&
			(drawY >= `HEART_Y) && (drawY < `HEART_Y + `HEART_H);
	end

	assign heartHit = |heartVec;

	//**************************************************
	// background bands
	//**************************************************
	// divider rows are inclusive at both ends
	assign lineHit = ((drawY >= `DIV0_TOP) && (drawY <= `DIV0_BOT)) ||
		((drawY >= `DIV1_TOP) && (drawY <= `DIV1_BOT));

	// water covers the top part of the screen
	assign waterHit = drawY < `WATER_END;

endmodule

/* source/sceneMixer.sv */
// pixel colour selection and collision flag
// frog on top, then lanes in order, then hud shapes and background
// collision registers whether the frog anchor sits on any vehicle
`timescale 1ns/1ps
`include "frogger_cfg.svh"

module sceneMixer
	import froggerPkg::*;
(
	input  logic       clk_4Hz,
	input  logic       arstN,
	input  coord_t     frogX,
	input  coord_t     frogY,
	input  coord_t     drawX,
	input  coord_t     drawY,
	input  logic [4:0] laneDrawHit,
	input  logic [4:0] laneFrogHit,
	input  logic       barHit,
	input  logic       heartHit,
	input  logic       lineHit,
	input  logic       waterHit,
	output colorCode_t colorCode,
	output logic       collision
);

	// one colour per lane, lane 0 first
	localparam colorCode_t laneColor [5] = '{colRed, colYellow, colOrange, colDarkBlue, colBrown};

	logic frogBox;

	assign frogBox = (drawX >= frogX) && (drawX < frogX + `FROG_W) &&
		(drawY >= frogY) && (drawY < frogY + `FROG_H);

	//**************************************************
	// colour priority
	//**************************************************
	always_comb
	begin
		colorCode = colDarkGrey;
		if (frogBox)
			colorCode = colLightGreen;
		else if (|laneDrawHit)
		begin
			// walk down so the lowest lane index wins
			for (int i = 4; i >= 0; i--)
			begin
				if (laneDrawHit[i])
					colorCode = laneColor[i];
			end
		end
		else if (lineHit)
			colorCode = colPurple;
		else if (barHit)
			colorCode = colGreen;
		else if (heartHit)
			colorCode = colRed;
		else if (waterHit)
			colorCode = colLightBlue;
	end

	//**************************************************
	// collision
	//**************************************************
	always_ff @(posedge clk_4Hz or negedge arstN)
	begin
		if (!arstN)
			collision <= 1'b0;
		else
			collision <= |laneFrogHit;
	end

	// lane positions and frog inputs must all be known once running
	assert property (@(posedge clk_4Hz) disable iff (!arstN)
		!$isunknown(collision))
	else
		$error("collision flag unknown");

endmodule

/* source/frogScene.sv */
// road scene top level
// five traffic lanes, time bar and hud feeding the colour mixer
`timescale 1ns/1ps
`include "frogger_cfg.svh"

module frogScene
	import froggerPkg::*;
(
	input  logic       clk_4Hz,
	input  logic       arstN,
	input  coord_t     frogX,
	input  coord_t     frogY,
	input  coord_t     drawX,
	input  coord_t     drawY,
	input  logic [2:0] lives,
	output colorCode_t colorCode,
	output logic       collision
);

	logic [4:0] laneDrawHit;
	logic [4:0] laneFrogHit;
	logic barHit;
	logic heartHit;
	logic lineHit;
	logic waterHit;

	//**************************************************
	// traffic lanes, bit index is the lane priority
	//**************************************************
	trafficLane #(
		.laneY(`FIRETRUCK_Y), .spriteW(`FIRETRUCK_W), .spriteH(`FIRETRUCK_H),
		.moveLeft(`FIRETRUCK_LEFT),
		.start0(`FIRETRUCK_X0), .start1(`FIRETRUCK_X1), .start2(`FIRETRUCK_X2),
		.start3(`FIRETRUCK_X3), .start4(`FIRETRUCK_X4)
	) i_fireLane (
		.clk_4Hz, .arstN, .drawX, .drawY, .frogX, .frogY,
		.drawHit(laneDrawHit[0]), .frogHit(laneFrogHit[0])
	);

	trafficLane #(
		.laneY(`BUS_Y), .spriteW(`BUS_W), .spriteH(`BUS_H), .moveLeft(`BUS_LEFT),
		.start0(`BUS_X0), .start1(`BUS_X1), .start2(`BUS_X2),
		.start3(`BUS_X3), .start4(`BUS_X4)
	) i_busLane (
		.clk_4Hz, .arstN, .drawX, .drawY, .frogX, .frogY,
		.drawHit(laneDrawHit[1]), .frogHit(laneFrogHit[1])
	);

	trafficLane #(
		.laneY(`MOTO_Y), .spriteW(`MOTO_W), .spriteH(`MOTO_H), .moveLeft(`MOTO_LEFT),
		.start0(`MOTO_X0), .start1(`MOTO_X1), .start2(`MOTO_X2),
		.start3(`MOTO_X3), .start4(`MOTO_X4)
	) i_motoLane (
		.clk_4Hz, .arstN, .drawX, .drawY, .frogX, .frogY,
		.drawHit(laneDrawHit[2]), .frogHit(laneFrogHit[2])
	);

	trafficLane #(
		.laneY(`POLICE_Y), .spriteW(`POLICE_W), .spriteH(`POLICE_H),
		.moveLeft(`POLICE_LEFT),
		.start0(`POLICE_X0), .start1(`POLICE_X1), .start2(`POLICE_X2),
		.start3(`POLICE_X3), .start4(`POLICE_X4)
	) i_policeLane (
		.clk_4Hz, .arstN, .drawX, .drawY, .frogX, .frogY,
		.drawHit(laneDrawHit[3]), .frogHit(laneFrogHit[3])
	);

	trafficLane #(
		.laneY(`TRUCK_Y), .spriteW(`TRUCK_W), .spriteH(`TRUCK_H), .moveLeft(`TRUCK_LEFT),
		.start0(`TRUCK_X0), .start1(`TRUCK_X1), .start2(`TRUCK_X2),
		.start3(`TRUCK_X3), .start4(`TRUCK_X4)
	) i_truckLane (
		.clk_4Hz, .arstN, .drawX, .drawY, .frogX, .frogY,
		.drawHit(laneDrawHit[4]), .frogHit(laneFrogHit[4])
	);

	//**************************************************
	// hud and mixer
	//**************************************************
	timeBar i_timeBar (.clk_4Hz, .arstN, .drawX, .drawY, .barHit);

	hudOverlay i_hudOverlay (.drawX, .drawY, .lives, .heartHit, .lineHit, .waterHit);

	sceneMixer i_sceneMixer (
		.clk_4Hz, .arstN, .frogX, .frogY, .drawX, .drawY,
		.laneDrawHit, .laneFrogHit,
		.barHit, .heartHit, .lineHit, .waterHit,
		.colorCode, .collision
	);

endmodule

/* bench/frogSceneModel.svh */
// reference model of the road scene
// vehicle positions, bar width and pixel colour from the tick count since reset
`ifndef FROG_SCENE_MODEL_SVH
`define FROG_SCENE_MODEL_SVH

// lane table in priority order, lane 0 first
localparam int laneYTab [5] = '{`FIRETRUCK_Y, `BUS_Y, `MOTO_Y, `POLICE_Y, `TRUCK_Y};
localparam int laneWTab [5] = '{`FIRETRUCK_W, `BUS_W, `MOTO_W, `POLICE_W, `TRUCK_W};
localparam int laneHTab [5] = '{`FIRETRUCK_H, `BUS_H, `MOTO_H, `POLICE_H, `TRUCK_H};
localparam bit laneLeftTab [5] = '{`FIRETRUCK_LEFT, `BUS_LEFT, `MOTO_LEFT,
	`POLICE_LEFT, `TRUCK_LEFT};
localparam int laneStartTab [5][5] = '{
	'{`FIRETRUCK_X0, `FIRETRUCK_X1, `FIRETRUCK_X2, `FIRETRUCK_X3, `FIRETRUCK_X4},
	'{`BUS_X0, `BUS_X1, `BUS_X2, `BUS_X3, `BUS_X4},
	'{`MOTO_X0, `MOTO_X1, `MOTO_X2, `MOTO_X3, `MOTO_X4},
	'{`POLICE_X0, `POLICE_X1, `POLICE_X2, `POLICE_X3, `POLICE_X4},
	'{`TRUCK_X0, `TRUCK_X1, `TRUCK_X2, `TRUCK_X3, `TRUCK_X4}
};
localparam colorCode_t laneColTab [5] = '{colRed, colYellow, colOrange, colDarkBlue, colBrown};

// a vehicle cycles through 641 positions from 0 up to the right edge
function automatic int vehicleX(input int lane, input int veh, input int ticks);
	int start;
	int span;
	start = laneStartTab[lane][veh];
	span = `SCREEN_W + 1;
	if (laneLeftTab[lane])
		return (start - ticks % span + span) % span;
	return (start + ticks) % span;
endfunction

function automatic bit inBox(input int px, input int py, input int bx, input int by,
	input int w, input int h);
	return (px >= bx) && (px < bx + w) && (py >= by) && (py < by + h);
endfunction

function automatic bit laneHitAt(input int lane, input int px, input int py,
	input int ticks);
	bit hit;
	hit = 1'b0;
	for (int v = 0; v < 5; v++)
		hit |= inBox(px, py, vehicleX(lane, v, ticks), laneYTab[lane],
			laneWTab[lane], laneHTab[lane]);
	return hit;
endfunction

// frog anchor on any vehicle of any lane
function automatic bit frogOnVehicle(input int fx, input int fy, input int ticks);
	bit hit;
	hit = 1'b0;
	for (int lane = 0; lane < 5; lane++)
		hit |= laneHitAt(lane, fx, fy, ticks);
	return hit;
endfunction

// one pixel less every BAR_DIV ticks and back to full after zero
function automatic int barWidthAt(input int ticks);
	return `BAR_MAX - ((ticks / `BAR_DIV) % (`BAR_MAX + 1));
endfunction

// heart k shows for lives k to 3
function automatic bit heartShown(input int px, input int py, input int lv);
	bit hit;
	hit = 1'b0;
	for (int k = 1; k <= 3; k++)
	begin
		if (lv >= k && lv <= 3)
			hit |= inBox(px, py, `HEART_X0 + (k - 1) * `HEART_STEP, `HEART_Y,
				`HEART_W, `HEART_H);
	end
	return hit;
endfunction

function automatic colorCode_t expectedColor(input int px, input int py, input int fx,
	input int fy, input int lv, input int ticks);
	if (inBox(px, py, fx, fy, `FROG_W, `FROG_H))
		return colLightGreen;
	for (int lane = 0; lane < 5; lane++)
	begin
		if (laneHitAt(lane, px, py, ticks))
			return laneColTab[lane];
	end
	if ((py >= `DIV0_TOP && py <= `DIV0_BOT) || (py >= `DIV1_TOP && py <= `DIV1_BOT))
		return colPurple;
	if (inBox(px, py, `BAR_X, `BAR_Y, barWidthAt(ticks), `BAR_H))
		return colGreen;
	if (heartShown(px, py, lv))
		return colRed;
	if (py < `WATER_END)
		return colLightBlue;
	return colDarkGrey;
endfunction

`endif

/* bench/frogSceneTb.sv */
// testbench for the road scene
// drives pixel, frog and lives inputs
// assertions compare with the reference model
`timescale 1ns/1ps
`include "frogger_cfg.svh"

module frogSceneTb
	import froggerPkg::*;
();

	localparam int clkPeriod = 100;
	localparam int runLimit  = 20000;

	logic       clk_4Hz;
	logic       arstN;
	coord_t     frogX;
	coord_t     frogY;
	coord_t     drawX;
	coord_t     drawY;
	logic [2:0] lives;
	colorCode_t colorCode;
	logic       collision;

	int         tickCount;
	logic       expColl;
	colorCode_t expColor;
	int         errors = 0;
	int         checks = 0;
	int         testCount = 0;
	int         testErrStart = 0;
	bit         edgeSeen;
	event       stallEv;

	`include "frogSceneModel.svh"

	frogScene i_frogScene (
		.clk_4Hz, .arstN, .frogX, .frogY, .drawX, .drawY, .lives,
		.colorCode, .collision
	);

	initial
	begin
		clk_4Hz = 1'b0;
		forever #(clkPeriod / 2) clk_4Hz = ~clk_4Hz;
	end

	// edges since reset drive the model
	always @(posedge clk_4Hz or negedge arstN)
	begin
		if (!arstN)
			tickCount <= 0;
		else
			tickCount <= tickCount + 1;
	end

	always @(posedge clk_4Hz or negedge arstN)
	begin
		if (!arstN)
			expColl <= 1'b0;
		else
			expColl <= frogOnVehicle(frogX, frogY, tickCount);
	end

	assign expColor = expectedColor(drawX, drawY, frogX, frogY, lives, tickCount);

	//**************************************************
	// checks
	//**************************************************
	assert property (@(posedge clk_4Hz) disable iff (!arstN) colorCode == expColor)
	begin
		checks++;
	end
	else
	begin
		errors++;
		$display("FAIL at %0t: colorCode expected %0d got %0d", $time,
			$sampled(expColor), $sampled(colorCode));
	end

	assert property (@(posedge clk_4Hz) disable iff (!arstN) collision == expColl)
	begin
		checks++;
	end
	else
	begin
		errors++;
		$display("FAIL at %0t: collision expected %0b got %0b", $time,
			$sampled(expColl), $sampled(collision));
	end

	//**************************************************
	// helpers
	//**************************************************
	// next falling edge with a two period timeout
	task nextFall();
		edgeSeen = 1'b0;
		fork
			begin
				@(negedge clk_4Hz);
				edgeSeen = 1'b1;
			end
			#(2 * clkPeriod);
		join_any
		disable fork;
		if (!edgeSeen)
		begin
			$display("no falling clock edge within two clock periods");
			->stallEv;
		end
	endtask

	task waitTicks(input int n);
		for (int i = 0; i < n; i++)
			nextFall();
	endtask

	task parkFrog();
		// frog sits in the water away from all lanes
		frogX = coord_t'(600);
		frogY = coord_t'(100);
	endtask

	task finishTest(input string name);
		// last checks of the test still pending
		nextFall();
		nextFall();
		testCount++;
		$display("test %0d %s: %0d errors", testCount, name, errors - testErrStart);
		testErrStart = errors;
	endtask

	//**************************************************
	// tests
	//**************************************************
	task resetCheck();
		for (int lane = 0; lane < 5; lane++)
		begin
			drawX = coord_t'(vehicleX(lane, 0, tickCount));
			drawY = coord_t'(laneYTab[lane]);
			nextFall();
		end
		finishTest("lane start positions");
	endtask

	task laneMotion();
		int veh;
		for (int i = 0; i < 14; i++)
		begin
			waitTicks($urandom_range(80, 40));
			veh = $urandom_range(4, 0);
			for (int lane = 0; lane < 5; lane++)
			begin
				drawX = coord_t'(vehicleX(lane, veh, tickCount) +
					$urandom_range(laneWTab[lane] - 1, 0));
				drawY = coord_t'(laneYTab[lane] + $urandom_range(laneHTab[lane] - 1, 0));
				nextFall();
			end
		end
		finishTest("lane motion and wrap");
	endtask

	task frogCollide();
		int lane;
		int veh;
		for (int i = 0; i < 20; i++)
		begin
			lane = $urandom_range(4, 0);
			veh = $urandom_range(4, 0);
			frogX = coord_t'(vehicleX(lane, veh, tickCount) +
				$urandom_range(laneWTab[lane] - 1, 0));
			frogY = coord_t'(laneYTab[lane] + $urandom_range(laneHTab[lane] - 1, 0));
			// frog pixel over the vehicle
			drawX = frogX;
			drawY = frogY;
			nextFall();
			// one row below the vehicle box is open road
			frogY = coord_t'(laneYTab[lane] + laneHTab[lane]);
			nextFall();
		end
		parkFrog();
		finishTest("frog collision");
	endtask

	task barCountdown();
		int period;
		int gap;
		period = `BAR_DIV * (`BAR_MAX + 1);
		for (int i = 0; i < 8; i++)
		begin
			waitTicks($urandom_range(20, 1));
			drawX = coord_t'(`BAR_X + $urandom_range(`BAR_MAX - 1, 0));
			drawY = coord_t'(`BAR_Y + $urandom_range(`BAR_H - 1, 0));
			nextFall();
		end
		// run up to the refill, then step across it at both bar edges
		gap = period - tickCount % period - 6;
		if (gap <= 0)
			gap += period;
		waitTicks(gap);
		for (int i = 0; i < 12; i++)
		begin
			drawX = coord_t'(`BAR_X + barWidthAt(tickCount) - (i % 2));
			drawY = coord_t'(`BAR_Y + $urandom_range(`BAR_H - 1, 0));
			nextFall();
		end
		finishTest("time bar width");
	endtask

	task heartLives();
		for (int lv = 0; lv < 8; lv++)
		begin
			for (int k = 0; k < 3; k++)
			begin
				lives = 3'(lv);
				drawX = coord_t'(`HEART_X0 + k * `HEART_STEP + $urandom_range(`HEART_W - 1, 0));
				drawY = coord_t'(`HEART_Y + $urandom_range(`HEART_H - 1, 0));
				nextFall();
			end
		end
		lives = 3'd3;
		finishTest("life hearts");
	endtask

	task backgroundBands();
		drawX = coord_t'($urandom_range(`SCREEN_W - 1, 0));
		drawY = coord_t'($urandom_range(`DIV0_BOT, `DIV0_TOP));
		nextFall();
		drawY = coord_t'($urandom_range(`DIV1_BOT, `DIV1_TOP));
		nextFall();
		// water pixel left of the parked frog
		drawX = coord_t'($urandom_range(580, 0));
		drawY = coord_t'($urandom_range(`WATER_END - 1, 0));
		nextFall();
		drawX = coord_t'($urandom_range(`SCREEN_W - 1, 0));
		drawY = coord_t'(450);
		nextFall();
		finishTest("dividers, water and background");
	endtask

	//**************************************************
	// main sequence
	//**************************************************
	initial
	begin
		void'($urandom(69));
		arstN = 1'b0;
		parkFrog();
		drawX = '0;
		drawY = '0;
		lives = 3'd3;
		waitTicks(3);
		arstN = 1'b1;
		resetCheck();
		laneMotion();
		frogCollide();
		barCountdown();
		heartLives();
		backgroundBands();
		$display("%0d tests, %0d checks, %0d errors", testCount, checks, errors);
		if (errors == 0)
			$display("TESTBENCH PASSED");
		else
			$display("TESTBENCH FAILED");
		$finish;
	end

	// stalled clock or a run far past its expected length
	initial
	begin
		fork
			#(runLimit * clkPeriod);
			@(stallEv);
		join_any
		$display("run stopped before all tests finished");
		$display("TESTBENCH FAILED");
		$finish;
	end

endmodule

/* flist.f */
+incdir+source
+incdir+bench
source/froggerPkg.sv
source/trafficLane.sv
source/timeBar.sv
source/hudOverlay.sv
source/sceneMixer.sv
source/frogScene.sv
bench/frogSceneTb.sv

/* Bender.yml */
package:
  name: frog_scene

export_include_dirs:
  - source

sources:
  - include_dirs:
      - source
    files:
      - source/froggerPkg.sv
      - source/trafficLane.sv
      - source/timeBar.sv
      - source/hudOverlay.sv
      - source/sceneMixer.sv
      - source/frogScene.sv
  - target: test
    include_dirs:
      - source
      - bench
    files:
      - bench/frogSceneTb.sv
